/* files.f */
+incdir+rtl
rtl/mm_pkg.sv
rtl/mm_job_regs.sv
rtl/mm_memory_scheduler.sv
rtl/mm_addr_gen.sv
rtl/mm_ctrl_fsm.sv
rtl/mm_sched_top.sv
sim/tb_mm_sched.sv

/* Bender.yml */
package:
  name: mm_sched

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/mm_pkg.sv
      - rtl/mm_job_regs.sv
      - rtl/mm_memory_scheduler.sv
      - rtl/mm_addr_gen.sv
      - rtl/mm_ctrl_fsm.sv
      - rtl/mm_sched_top.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - sim/tb_mm_sched.sv

/* sim/tb_mm_sched.sv */
`timescale 1ns/1ps
`include "mm_defs.svh"
`default_nettype none

module tb_mm_sched
  import mm_pkg::*;
();

  localparam int NumJobs = 4;
  localparam int NumCols = 8;

  // Job table columns
  localparam int ColXAddr    = 0;
  localparam int ColStride   = 1;
  localparam int ColRowsOffs = 2;
  localparam int ColCols     = 3;
  localparam int ColW        = 4;
  localparam int ColRows     = 5;
  localparam int ColLeftover = 6;
  localparam int ColBeats    = 7;

  logic                  clk;
  logic                  rst_n;
  logic                  cfg_req;
  cfg_reg_e              cfg_addr;
  logic [`MM_CFG_DW-1:0] cfg_wdata;
  logic                  cfg_ack;
  logic                  mem_req;
  logic [`MM_ADDR_W-1:0] mem_addr;
  logic                  mem_ack;
  logic                  busy;
  logic                  done;

  logic [31:0] job_tab [NumJobs*NumCols];
  logic [31:0] exp_q [$];
  logic [7:0]  lfsr_q = 8'd68;
  logic        req_seen = 1'b0;
  int unsigned cycle_cnt = 0;
  int unsigned cycle_limit = 0;
  int unsigned beat_cnt = 0;
  int unsigned err_cnt = 0;

  mm_sched_top UUT (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .cfg_req_i   (cfg_req),
    .cfg_addr_i  (cfg_addr),
    .cfg_wdata_i (cfg_wdata),
    .cfg_ack_o   (cfg_ack),
    .mem_req_o   (mem_req),
    .mem_addr_o  (mem_addr),
    .mem_ack_i   (mem_ack),
    .busy_o      (busy),
    .done_o      (done)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      err_cnt++;
      $display("MISMATCH time=%0t %s: got 0x%0h, expected 0x%0h", $time, name, got, exp);
      $display("test failed");
      $fatal(1, "value mismatch on %s", name);
    end
  endtask

  // 8-bit Fibonacci LFSR with taps 8 6 5 4
  function automatic logic [7:0] lfsr_next(input logic [7:0] s);
    logic fb;
    fb = s[7] ^ s[5] ^ s[4] ^ s[3];
    return {s[6:0], fb};
  endfunction

  task automatic draw_delay(output int unsigned dly);
    dly = 0;
    for (int b = 0; b < 2; b++) begin
      lfsr_q = lfsr_next(lfsr_q);
      dly = (dly << 1) | lfsr_q[0];
    end
  endtask

  task automatic set_job(input int j, input logic [31:0] x_addr, input logic [31:0] stride,
                         input logic [31:0] rows_offs, input logic [31:0] cols,
                         input logic [31:0] w_it, input logic [31:0] rows,
                         input logic [31:0] leftover, input logic [31:0] beats);
    job_tab[j*NumCols+ColXAddr]    = x_addr;
    job_tab[j*NumCols+ColStride]   = stride;
    job_tab[j*NumCols+ColRowsOffs] = rows_offs;
    job_tab[j*NumCols+ColCols]     = cols;
    job_tab[j*NumCols+ColW]        = w_it;
    job_tab[j*NumCols+ColRows]     = rows;
    job_tab[j*NumCols+ColLeftover] = leftover;
    job_tab[j*NumCols+ColBeats]    = beats;
  endtask

  task automatic load_job_table();
    // Single tile
    set_job(0, 32'h1000, 32'h40, 32'h100, 1, 1, 1, 0, 4);
    // Columns, then W repeats, then rows
    set_job(1, 32'h2000, 32'h20, 32'h200, 3, 2, 2, 0, 48);
    // Short last row block
    set_job(2, 32'h8000, 32'h10, 32'h080, 2, 1, 3, 3, 22);
    // Only one row block so every tile is short
    set_job(3, 32'h4000, 32'h08, 32'h040, 2, 3, 1, 2, 12);
  endtask

  // Expected read addresses of one job from the nested tile loops
  task automatic build_expected(input int j);
    int unsigned x_addr;
    int unsigned stride;
    int unsigned rows_offs;
    int unsigned cols;
    int unsigned w_it;
    int unsigned rows;
    int unsigned left;
    int unsigned base;
    int unsigned len;
    int unsigned beats;
    x_addr    = job_tab[j*NumCols+ColXAddr];
    stride    = job_tab[j*NumCols+ColStride];
    rows_offs = job_tab[j*NumCols+ColRowsOffs];
    cols      = job_tab[j*NumCols+ColCols];
    w_it      = job_tab[j*NumCols+ColW];
    rows      = job_tab[j*NumCols+ColRows];
    left      = job_tab[j*NumCols+ColLeftover];
    beats     = 0;
    for (int unsigned r = 0; r < rows; r++) begin
      for (int unsigned wi = 0; wi < w_it; wi++) begin
        for (int unsigned c = 0; c < cols; c++) begin
          base = x_addr + r * rows_offs + c * `MM_JMP;
          len  = (r == rows - 1 && left != 0) ? left : `MM_ARRAY_W;
          for (int unsigned k = 0; k < len; k++) begin
            exp_q.push_back(base + k * stride);
            beats++;
          end
        end
      end
    end
    check_value("model beat count", beats, job_tab[j*NumCols+ColBeats]);
  endtask

  // Four-phase write where ack follows each req edge after one cycle
  task automatic write_reg(input cfg_reg_e addr, input logic [31:0] data);
    int unsigned n;
    @(negedge clk);
    cfg_req   = 1'b1;
    cfg_addr  = addr;
    cfg_wdata = data;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!cfg_ack);
    check_value("cfg_ack_o rise latency", n, 1);
    cfg_req = 1'b0;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (cfg_ack);
    check_value("cfg_ack_o fall latency", n, 1);
  endtask

  task automatic program_job(input int j);
    for (int f = 0; f < 7; f++) begin
      write_reg(cfg_reg_e'(f), job_tab[j*NumCols+f]);
    end
  endtask

  task automatic wait_done();
    while (!done) begin
      @(negedge clk);
    end
  endtask

  // Memory responder with random ack and release latency
  initial begin : mem_responder
    int unsigned dly;
    mem_ack = 1'b0;
    forever begin
      @(negedge clk);
      if (rst_n && mem_req && !mem_ack) begin
        draw_delay(dly);
        repeat (dly) @(negedge clk);
        mem_ack = 1'b1;
        do begin
          @(negedge clk);
        end while (mem_req);
        draw_delay(dly);
        repeat (dly) @(negedge clk);
        mem_ack = 1'b0;
      end
    end
  end

  // Each new beat is compared against the reference queue
  always @(negedge clk) begin
    req_seen <= mem_req;
    if (rst_n && mem_req && !req_seen) begin
      if (exp_q.size() == 0) begin
        $display("unexpected memory read at %0t, address 0x%0h", $time, mem_addr);
        $display("test failed");
        $fatal(1, "memory read beyond the expected sequence");
      end else begin
        beat_cnt++;
        check_value("mem_addr_o", mem_addr, exp_q.pop_front());
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
      $display("timeout: job table did not finish within %0d cycles", cycle_limit);
      $display("test failed");
      $fatal(1, "simulation timed out");
    end
  end

  initial begin : main_seq
    int unsigned total_beats;
    rst_n     = 1'b0;
    cfg_req   = 1'b0;
    cfg_addr  = REG_X_ADDR;
    cfg_wdata = '0;
    load_job_table();
    total_beats = 0;
    for (int j = 0; j < NumJobs; j++) begin
      total_beats += job_tab[j*NumCols+ColBeats];
    end
    cycle_limit = total_beats * 12 + 200;

    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    check_value("cfg_ack_o", cfg_ack, 0);
    check_value("mem_req_o", mem_req, 0);
    check_value("busy_o", busy, 0);
    check_value("done_o", done, 0);

    for (int j = 0; j < NumJobs; j++) begin
      exp_q.delete();
      beat_cnt = 0;
      build_expected(j);
      program_job(j);
      write_reg(REG_CMD, 32'd1);
      check_value("busy_o", busy, 1);
      check_value("done_o", done, 0);
      wait_done();
      check_value("beats issued", beat_cnt, job_tab[j*NumCols+ColBeats]);
      check_value("expected addresses left", exp_q.size(), 0);
      check_value("busy_o", busy, 0);
    end

    if (err_cnt == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* rtl/mm_sched_top.sv */
`timescale 1ns/1ps
`include "mm_defs.svh"
`default_nettype none

module mm_sched_top
  import mm_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  cfg_req_i,
  input  cfg_reg_e              cfg_addr_i,
  input  logic [`MM_CFG_DW-1:0] cfg_wdata_i,
  output logic                  cfg_ack_o,
  output logic                  mem_req_o,
  output logic [`MM_ADDR_W-1:0] mem_addr_o,
  input  logic                  mem_ack_i,
  output logic                  busy_o,
  output logic                  done_o
);

  logic                  start;
  logic                  first_load;
  logic                  run;
  logic [`MM_ADDR_W-1:0] x_addr;
  logic [`MM_ADDR_W-1:0] x_d1_stride;
  logic [`MM_ADDR_W-1:0] x_rows_offs;
  logic [`MM_CNT_W-1:0]  cols_iters;
  logic [`MM_CNT_W-1:0]  w_iters;
  logic [`MM_CNT_W-1:0]  rows_iters;
  logic [`MM_CNT_W-1:0]  leftover;
  logic                  tile_req;
  logic [`MM_ADDR_W-1:0] tile_base;
  logic [`MM_CNT_W-1:0]  tile_len;
  logic [`MM_ADDR_W-1:0] tile_stride;
  logic                  tile_ack;
  logic                  tile_done;

  mm_job_regs i_job_regs (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .cfg_req_i     (cfg_req_i),
    .cfg_addr_i    (cfg_addr_i),
    .cfg_wdata_i   (cfg_wdata_i),
    .cfg_ack_o     (cfg_ack_o),
    .busy_i        (busy_o),
    .start_o       (start),
    .x_addr_o      (x_addr),
    .x_d1_stride_o (x_d1_stride),
    .x_rows_offs_o (x_rows_offs),
    .cols_iters_o  (cols_iters),
    .w_iters_o     (w_iters),
    .rows_iters_o  (rows_iters),
    .leftover_o    (leftover)
  );

  mm_ctrl_fsm i_ctrl_fsm (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .start_i      (start),
    .tile_done_i  (tile_done),
    .cols_iters_i (cols_iters),
    .w_iters_i    (w_iters),
    .rows_iters_i (rows_iters),
    .first_load_o (first_load),
    .run_o        (run),
    .busy_o       (busy_o),
    .done_o       (done_o)
  );

  mm_memory_scheduler i_memory_scheduler (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .run_i         (run),
    .first_load_i  (first_load),
    .tile_done_i   (tile_done),
    .x_addr_i      (x_addr),
    .x_d1_stride_i (x_d1_stride),
    .x_rows_offs_i (x_rows_offs),
    .cols_iters_i  (cols_iters),
    .w_iters_i     (w_iters),
    .rows_iters_i  (rows_iters),
    .leftover_i    (leftover),
    .tile_req_o    (tile_req),
    .tile_base_o   (tile_base),
    .tile_len_o    (tile_len),
    .tile_stride_o (tile_stride),
    .tile_ack_i    (tile_ack)
  );

  mm_addr_gen i_addr_gen (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .tile_req_i    (tile_req),
    .tile_base_i   (tile_base),
    .tile_len_i    (tile_len),
    .tile_stride_i (tile_stride),
    .tile_ack_o    (tile_ack),
    .tile_done_o   (tile_done),
    .mem_req_o     (mem_req_o),
    .mem_addr_o    (mem_addr_o),
    .mem_ack_i     (mem_ack_i)
  );

endmodule

`default_nettype wire

/* rtl/mm_ctrl_fsm.sv */
`timescale 1ns/1ps
`include "mm_defs.svh"
`default_nettype none

module mm_ctrl_fsm
  import mm_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 start_i,
  input  logic                 tile_done_i,
  input  logic [`MM_CNT_W-1:0] cols_iters_i,
  input  logic [`MM_CNT_W-1:0] w_iters_i,
  input  logic [`MM_CNT_W-1:0] rows_iters_i,
  output logic                 first_load_o,
  output logic                 run_o,
  output logic                 busy_o,
  output logic                 done_o
);

  localparam int unsigned TotW = 3 * `MM_CNT_W;

  ctrl_state_e     state_q;
  logic [TotW-1:0] tot_q;
  logic [TotW-1:0] done_cnt_q;
  logic [TotW-1:0] done_cnt_next;
  logic            empty_job;

  assign empty_job     = (cols_iters_i == '0) || (w_iters_i == '0) || (rows_iters_i == '0);
  assign done_cnt_next = done_cnt_q + 1'b1;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= ST_IDLE;
      tot_q      <= '0;
      done_cnt_q <= '0;
    end else begin
      case (state_q)
        ST_IDLE, ST_DONE: begin
          if (start_i) begin
            tot_q      <= cols_iters_i * w_iters_i * rows_iters_i;
            done_cnt_q <= '0;
            state_q    <= empty_job ? ST_DONE : ST_FIRST;
          end
        end
        ST_FIRST, ST_RUN: begin
          if (tile_done_i) begin
            done_cnt_q <= done_cnt_next;
            state_q    <= (done_cnt_next == tot_q) ? ST_DONE : ST_RUN;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  assign first_load_o = (state_q == ST_FIRST);
  assign run_o        = (state_q == ST_FIRST) || (state_q == ST_RUN);
  assign busy_o       = run_o;
  assign done_o       = (state_q == ST_DONE);

endmodule

`default_nettype wire

/* rtl/mm_addr_gen.sv */
`timescale 1ns/1ps
`include "mm_defs.svh"
`default_nettype none

module mm_addr_gen (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  tile_req_i,
  input  logic [`MM_ADDR_W-1:0] tile_base_i,
  input  logic [`MM_CNT_W-1:0]  tile_len_i,
  input  logic [`MM_ADDR_W-1:0] tile_stride_i,
  output logic                  tile_ack_o,
  output logic                  tile_done_o,
  output logic                  mem_req_o,
  output logic [`MM_ADDR_W-1:0] mem_addr_o,
  input  logic                  mem_ack_i
);

  typedef enum logic [1:0] {
    G_IDLE    = 2'd0,
    G_LAUNCH  = 2'd1,
    G_REQ     = 2'd2,
    G_RELEASE = 2'd3
  } gen_state_e;

  gen_state_e            state_q;
  logic                  tile_ack_q;
  logic                  mem_req_q;
  logic                  done_q;
  logic                  accept;
  logic                  last_beat;
  logic [`MM_CNT_W-1:0]  beat_q;
  logic [`MM_CNT_W-1:0]  len_q;
  logic [`MM_ADDR_W-1:0] stride_q;
  logic [`MM_ADDR_W-1:0] addr_q;

  assign accept    = (state_q == G_IDLE) && tile_req_i && !tile_ack_q;
  assign last_beat = (beat_q == len_q - 1'b1);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      tile_ack_q <= 1'b0;
    end else if (accept) begin
      tile_ack_q <= 1'b1;
    end else if (tile_ack_q && !tile_req_i) begin
      tile_ack_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      len_q    <= tile_len_i;
      stride_q <= tile_stride_i;
      addr_q   <= tile_base_i;
    end else if (state_q == G_RELEASE && !mem_ack_i && !last_beat) begin
      addr_q <= addr_q + stride_q;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= G_IDLE;
      mem_req_q <= 1'b0;
      done_q    <= 1'b0;
      beat_q    <= '0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        G_IDLE: begin
          if (accept) begin
            beat_q  <= '0;
            state_q <= G_LAUNCH;
          end
        end
        G_LAUNCH: begin
          mem_req_q <= 1'b1;
          state_q   <= G_REQ;
        end
        G_REQ: begin
          if (mem_ack_i) begin
            mem_req_q <= 1'b0;
            state_q   <= G_RELEASE;
          end
        end
        G_RELEASE: begin
          // Wait for the memory to drop ack before the next beat
          if (!mem_ack_i) begin
            if (last_beat) begin
              done_q  <= 1'b1;
              state_q <= G_IDLE;
            end else begin
              beat_q    <= beat_q + 1'b1;
              mem_req_q <= 1'b1;
              state_q   <= G_REQ;
            end
          end
        end
        default: state_q <= G_IDLE;
      endcase
    end
  end

  assign tile_ack_o  = tile_ack_q;
  assign tile_done_o = done_q;
  assign mem_req_o   = mem_req_q;
  assign mem_addr_o  = addr_q;

  a_mem_addr_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req_o && $past(mem_req_o) |-> $stable(mem_addr_o))
    else $error("mem_addr_o changed while mem_req_o was high");

endmodule

`default_nettype wire

/* rtl/mm_memory_scheduler.sv */
`timescale 1ns/1ps
`include "mm_defs.svh"
`default_nettype none

module mm_memory_scheduler (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  run_i,
  input  logic                  first_load_i,
  input  logic                  tile_done_i,
  input  logic [`MM_ADDR_W-1:0] x_addr_i,
  input  logic [`MM_ADDR_W-1:0] x_d1_stride_i,
  input  logic [`MM_ADDR_W-1:0] x_rows_offs_i,
  input  logic [`MM_CNT_W-1:0]  cols_iters_i,
  input  logic [`MM_CNT_W-1:0]  w_iters_i,
  input  logic [`MM_CNT_W-1:0]  rows_iters_i,
  input  logic [`MM_CNT_W-1:0]  leftover_i,
  output logic                  tile_req_o,
  output logic [`MM_ADDR_W-1:0] tile_base_o,
  output logic [`MM_CNT_W-1:0]  tile_len_o,
  output logic [`MM_ADDR_W-1:0] tile_stride_o,
  input  logic                  tile_ack_i
);

  logic [`MM_CNT_W-1:0]  col_cnt_q;
  logic [`MM_CNT_W-1:0]  w_cnt_q;
  logic [`MM_CNT_W-1:0]  row_cnt_q;
  logic [`MM_ADDR_W-1:0] col_offs_q;
  logic [`MM_ADDR_W-1:0] row_offs_q;
  logic                  col_last;
  logic                  w_last;
  logic                  row_last;
  logic                  first_load_q;
  logic                  clear;
  logic                  tile_req_q;
  logic                  pending_q;
  logic                  launch;

  assign col_last = (col_cnt_q == cols_iters_i - 1'b1);
  assign w_last   = (w_cnt_q == w_iters_i - 1'b1);
  assign row_last = (row_cnt_q == rows_iters_i - 1'b1);

  // New job starts from tile zero
  assign clear = first_load_i && !first_load_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      first_load_q <= 1'b0;
    end else begin
      first_load_q <= first_load_i;
    end
  end

  // Columns innermost, then W repeats, then row blocks
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      col_cnt_q  <= '0;
      w_cnt_q    <= '0;
      row_cnt_q  <= '0;
      col_offs_q <= '0;
      row_offs_q <= '0;
    end else if (clear) begin
      col_cnt_q  <= '0;
      w_cnt_q    <= '0;
      row_cnt_q  <= '0;
      col_offs_q <= '0;
      row_offs_q <= '0;
    end else if (tile_done_i) begin
      col_cnt_q  <= col_last ? '0 : col_cnt_q + 1'b1;
      col_offs_q <= col_last ? '0 : col_offs_q + `MM_ADDR_W'(`MM_JMP);
      if (col_last) begin
        w_cnt_q <= w_last ? '0 : w_cnt_q + 1'b1;
      end
      if (col_last && w_last) begin
        row_cnt_q  <= row_last ? '0 : row_cnt_q + 1'b1;
        row_offs_q <= row_last ? '0 : row_offs_q + x_rows_offs_i;
      end
    end
  end

  // Next tile only once the last one has been handed off and finished
  assign launch = run_i && !tile_req_q && !pending_q && !tile_ack_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      tile_req_q <= 1'b0;
      pending_q  <= 1'b0;
    end else begin
      if (launch) begin
        tile_req_q <= 1'b1;
        pending_q  <= 1'b1;
      end else begin
        if (tile_req_q && tile_ack_i) begin
          tile_req_q <= 1'b0;
        end
        if (tile_done_i) begin
          pending_q <= 1'b0;
        end
      end
    end
  end

  assign tile_req_o    = tile_req_q;
  assign tile_base_o   = x_addr_i + row_offs_q + col_offs_q;
  assign tile_stride_o = x_d1_stride_i;
  // Short last row block when the row count is not a multiple of the array
  assign tile_len_o    = (row_last && leftover_i != '0) ? leftover_i
                                                         : `MM_CNT_W'(`MM_ARRAY_W);

  a_cnt_range: assert property (@(posedge clk_i) disable iff (!rst_ni)
    tile_req_o |-> (col_cnt_q < cols_iters_i) && (w_cnt_q < w_iters_i) &&
                   (row_cnt_q < rows_iters_i))
    else $error("tile counter beyond its iteration count");

endmodule

`default_nettype wire

/* rtl/mm_job_regs.sv */
`timescale 1ns/1ps
`include "mm_defs.svh"
`default_nettype none

module mm_job_regs
  import mm_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  cfg_req_i,
  input  cfg_reg_e              cfg_addr_i,
  input  logic [`MM_CFG_DW-1:0] cfg_wdata_i,
  output logic                  cfg_ack_o,
  input  logic                  busy_i,
  output logic                  start_o,
  output logic [`MM_ADDR_W-1:0] x_addr_o,
  output logic [`MM_ADDR_W-1:0] x_d1_stride_o,
  output logic [`MM_ADDR_W-1:0] x_rows_offs_o,
  output logic [`MM_CNT_W-1:0]  cols_iters_o,
  output logic [`MM_CNT_W-1:0]  w_iters_o,
  output logic [`MM_CNT_W-1:0]  rows_iters_o,
  output logic [`MM_CNT_W-1:0]  leftover_o
);

  logic ack_q;
  logic cfg_we;

  // One write per handshake, on the edge where ack rises
  assign cfg_we    = cfg_req_i && !ack_q;
  assign cfg_ack_o = ack_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q <= 1'b0;
    end else if (cfg_we) begin
      ack_q <= 1'b1;
    end else if (ack_q && !cfg_req_i) begin
      ack_q <= 1'b0;
    end
  end

  // Parameters stay frozen while a job runs
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      x_addr_o      <= '0;
      x_d1_stride_o <= '0;
      x_rows_offs_o <= '0;
      cols_iters_o  <= '0;
      w_iters_o     <= '0;
      rows_iters_o  <= '0;
      leftover_o    <= '0;
    end else if (cfg_we && !busy_i) begin
      case (cfg_addr_i)
        REG_X_ADDR:      x_addr_o      <= cfg_wdata_i[`MM_ADDR_W-1:0];
        REG_X_D1_STRIDE: x_d1_stride_o <= cfg_wdata_i[`MM_ADDR_W-1:0];
        REG_X_ROWS_OFFS: x_rows_offs_o <= cfg_wdata_i[`MM_ADDR_W-1:0];
        REG_COLS_ITERS:  cols_iters_o  <= cfg_wdata_i[`MM_CNT_W-1:0];
        REG_W_ITERS:     w_iters_o     <= cfg_wdata_i[`MM_CNT_W-1:0];
        REG_ROWS_ITERS:  rows_iters_o  <= cfg_wdata_i[`MM_CNT_W-1:0];
        REG_LEFTOVER:    leftover_o    <= cfg_wdata_i[`MM_CNT_W-1:0];
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      start_o <= 1'b0;
    end else begin
      start_o <= cfg_we && !busy_i && (cfg_addr_i == REG_CMD) &&
                 (cfg_wdata_i == `MM_CFG_DW'(1));
    end
  end

  a_cfg_addr_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cfg_req_i && $past(cfg_req_i) |-> $stable(cfg_addr_i))
    else $error("cfg_addr_i changed while cfg_req_i was high");

endmodule

`default_nettype wire

/* rtl/mm_pkg.sv */
`default_nettype none

package mm_pkg;

  // Config port register index, used as the write opcode
  typedef enum logic [2:0] {
    REG_X_ADDR      = 3'd0,
    REG_X_D1_STRIDE = 3'd1,
    REG_X_ROWS_OFFS = 3'd2,
    REG_COLS_ITERS  = 3'd3,
    REG_W_ITERS     = 3'd4,
    REG_ROWS_ITERS  = 3'd5,
    REG_LEFTOVER    = 3'd6,
    REG_CMD         = 3'd7
  } cfg_reg_e;

  typedef enum logic [1:0] {
    ST_IDLE  = 2'd0,
    ST_FIRST = 2'd1,
    ST_RUN   = 2'd2,
    ST_DONE  = 2'd3
  } ctrl_state_e;

endpackage

`default_nettype wire

/* rtl/mm_defs.svh */
`ifndef MM_DEFS_SVH
`define MM_DEFS_SVH

// X rows fetched per full tile
`define MM_ARRAY_W 4

// Memory address width
`define MM_ADDR_W 32

// Iteration counter width
`define MM_CNT_W 16

// Config port data width
`define MM_CFG_DW 32

// Byte step between horizontally adjacent tiles
`define MM_JMP 16

`endif
